// File: vlog.f
logic/fxp_pkg.sv
logic/fxp_if.sv
logic/fxp_decoder.sv
logic/fxp_register_file.sv
logic/fxp_forwarding.sv
logic/fixed_point_unit.sv
logic/fxp_execute_top.sv
testbench/fxp_execute_asserts.sv
testbench/fxp_execute_tb.sv

// File: testbench/fxp_execute_tb.sv
`default_nettype none

module fxp_execute_tb;

    localparam int NUM_INSTR  = 30;                   // Strobes over all tests
    localparam int CLK_PERIOD = 10;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    fxp_pkg::fxp_word_t instr;
    fxp_pkg::fxp_word_t int_operand;
    logic               result_valid;
    fxp_pkg::fxp_word_t result;
    logic               result_is_int;
    logic               illegal;

    fxp_pkg::fxp_word_t ref_regs [32];                // Model of f0..f31
    int                 flen;                         // Taken from the DUT
    int                 errors;
    int                 tests_run;
    int                 tests_passed;

    fxp_execute_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .int_operand   (int_operand),
        .result_valid  (result_valid),
        .result        (result),
        .result_is_int (result_is_int),
        .illegal       (illegal)
    );

    always #5 clk = ~clk;

    // Watchdog, 4 cycles per strobe plus slack
    initial begin
        #((NUM_INSTR * 4 + 100) * CLK_PERIOD);
        $display("Watchdog expired, the tests did not complete in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic fxp_pkg::fxp_word_t encode(input logic [6:0] f7,
            input fxp_pkg::reg_index_t rs2, input fxp_pkg::reg_index_t rs1,
            input logic [2:0] f3, input fxp_pkg::reg_index_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};           // R-type layout
    endfunction

    task automatic check_word(input string name, input fxp_pkg::fxp_word_t exp,
                              input fxp_pkg::fxp_word_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // Inputs change on the falling edge only
    task automatic send(input fxp_pkg::fxp_word_t word, input fxp_pkg::fxp_word_t opnd);
        instr_valid = 1'b1;
        instr       = word;
        int_operand = opnd;
        @(negedge clk);                               // Now in cycle N+1
    endtask

    task automatic idle(input int cycles);
        instr_valid = 1'b0;
        instr       = '0;
        int_operand = '0;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic expect_result(input fxp_pkg::fxp_word_t exp, input logic exp_int);
        check_flag("result_valid", 1'b1, result_valid);
        check_word("result", exp, result);
        check_flag("result_is_int", exp_int, result_is_int);
        check_flag("illegal", 1'b0, illegal);
    endtask

    task automatic expect_none(input logic exp_ill);
        check_flag("result_valid", 1'b0, result_valid);
        check_flag("illegal", exp_ill, illegal);
    endtask

    // FCVT.S.W or FCVT.S.WU, int shifted up by FLEN
    task automatic load(input fxp_pkg::reg_index_t rd, input fxp_pkg::fxp_word_t value,
                        input logic uns);
        fxp_pkg::fxp_word_t exp;
        exp = value << flen;
        send(encode(fxp_pkg::FUNCT7_FCVT_S_W, {4'b0, uns}, 5'd0, 3'b111, rd,
                    fxp_pkg::OPCODE_OP_FP), value);
        ref_regs[rd] = exp;
        expect_result(exp, 1'b0);
    endtask

    // FADD.S or FSUB.S, wraps modulo 2^32
    task automatic arith(input fxp_pkg::reg_index_t rd, input fxp_pkg::reg_index_t rs1,
                         input fxp_pkg::reg_index_t rs2, input logic sub);
        fxp_pkg::fxp_word_t exp;
        exp = sub ? ref_regs[rs1] - ref_regs[rs2] : ref_regs[rs1] + ref_regs[rs2];
        send(encode(sub ? fxp_pkg::FUNCT7_FSUB : fxp_pkg::FUNCT7_FADD, rs2, rs1, 3'b000,
                    rd, fxp_pkg::OPCODE_OP_FP), $urandom());  // Int input ignored
        ref_regs[rd] = exp;
        expect_result(exp, 1'b0);
    endtask

    // FCVT.W.S arithmetic, FCVT.WU.S logical
    task automatic to_int(input fxp_pkg::reg_index_t rd, input fxp_pkg::reg_index_t rs1,
                          input logic uns);
        fxp_pkg::fxp_word_t exp;
        fxp_pkg::fxp_word_t fill;                     // Vacated top bits
        fill = (ref_regs[rs1][31] && !uns) ? ~(32'hFFFF_FFFF >> flen) : 32'h0;
        exp  = (ref_regs[rs1] >> flen) | fill;
        send(encode(fxp_pkg::FUNCT7_FCVT_W_S, {4'b0, uns}, rs1, 3'b001, rd,
                    fxp_pkg::OPCODE_OP_FP), '0);
        expect_result(exp, 1'b1);                     // No f register written
    endtask

    task automatic bad_op(input fxp_pkg::fxp_word_t word);
        send(word, $urandom());
        expect_none(1'b1);
        idle(1);
        expect_none(1'b0);                            // Single-cycle pulse
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errs_before);
        end
    endtask

    task automatic test_reset_convert();
        int start;
        start = errors;
        expect_none(1'b0);                            // Nothing valid after reset
        for (int i = 1; i <= 6; i++) begin
            load(fxp_pkg::reg_index_t'(i), $urandom(), i > 3);
        end
        idle(1);
        expect_none(1'b0);
        finish_test("reset and conversion into fixed point", start);
    endtask

    task automatic test_add_sub();
        int start;
        start = errors;
        load(8, $urandom(), 1'b0);
        load(9, $urandom(), 1'b1);
        idle(2);                                      // Operands now in the regfile
        arith(10, 8, 9, 1'b0);
        arith(11, 8, 9, 1'b1);
        arith(12, 1, 2, 1'b1);
        idle(2);
        finish_test("add and subtract from the register file", start);
    endtask

    task automatic test_forward_chain();
        int                  start;
        fxp_pkg::reg_index_t prev;
        start = errors;
        load(13, $urandom(), 1'b0);
        prev = 13;
        for (int i = 0; i < 6; i++) begin             // Each reads the previous rd
            arith(fxp_pkg::reg_index_t'(14 + i), prev, (i % 2 == 1) ? prev : 5'd4, i == 3);
            prev = fxp_pkg::reg_index_t'(14 + i);
        end
        idle(1);
        expect_none(1'b0);
        finish_test("back-to-back forwarding", start);
    endtask

    task automatic test_convert_out();
        int start;
        start = errors;
        load(20, -int'($urandom_range(100000, 1)), 1'b0);
        load(21, $urandom_range(100000, 1), 1'b1);
        idle(2);
        to_int(20, 20, 1'b0);                         // rd names an x register
        to_int(20, 20, 1'b1);
        to_int(21, 21, 1'b0);
        to_int(21, 21, 1'b1);
        arith(22, 20, 21, 1'b0);                      // f20 and f21 untouched
        idle(2);
        finish_test("conversions to integer", start);
    endtask

    task automatic test_illegal();
        int start;
        start = errors;
        bad_op(encode(7'b0001000, 5'd2, 5'd1, 3'b000, 5'd1, fxp_pkg::OPCODE_OP_FP));
        bad_op(encode(fxp_pkg::FUNCT7_FADD, 5'd2, 5'd1, 3'b000, 5'd2, 7'b0110011));
        bad_op(encode(fxp_pkg::FUNCT7_FCVT_S_W, 5'd2, 5'd0, 3'b111, 5'd3,
                      fxp_pkg::OPCODE_OP_FP));
        arith(25, 1, 2, 1'b0);                        // f1..f3 must be intact
        arith(26, 3, 3, 1'b0);
        idle(1);
        finish_test("illegal encodings", start);
    endtask

    initial begin
        void'($urandom(63));                          // Fixed seed for the run
        flen         = DUT.FLEN;
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        int_operand  = '0;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;                         // Matches the register reset
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_convert();
        test_add_sub();
        test_forward_chain();
        test_convert_out();
        test_illegal();
        errors += DUT.u_asserts.fail_count;
        $display("%0d of %0d tests passed, %0d check errors", tests_passed, tests_run,
                 errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/fxp_execute_asserts.sv
`default_nettype none

module fxp_execute_asserts (
    input logic clk,
    input logic rst_n,
    input logic op_valid,                             // Decoder accepted the strobe
    input logic result_valid,
    input logic illegal
);

    int unsigned fail_count = 0;                      // Assertion failures so far

    // Completion and reject are exclusive
    one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_valid && illegal))
        else begin
            fail_count++;
            $error("result_valid and illegal high in the same cycle");
        end

    // Quiet outputs during reset
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!result_valid && !illegal))
        else begin
            fail_count++;
            $error("output active while rst_n is low");
        end

    // Fixed one-cycle latency
    result_next_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |=> result_valid)
        else begin
            fail_count++;
            $error("legal instruction not followed by result_valid");
        end

endmodule

bind fxp_execute_top fxp_execute_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid     (op_bus.valid),
    .result_valid (result_valid),
    .illegal      (illegal)
);

`default_nettype wire

// File: logic/fxp_execute_top.sv
`default_nettype none

module fxp_execute_top #(
    parameter int unsigned FLEN = 10                  // Fractional bits
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,          // One-cycle strobe
    input  fxp_pkg::fxp_word_t  instr,
    input  fxp_pkg::fxp_word_t  int_operand,          // Stands in for x[rs1]
    output logic                result_valid,
    output fxp_pkg::fxp_word_t  result,
    output logic                result_is_int,        // FCVT.W.S / FCVT.WU.S
    output logic                illegal
);

    fxp_op_if op_bus ();
    fxp_wb_if wb_bus ();

    logic               illegal_now;
    fxp_pkg::fxp_word_t rs1_data;
    fxp_pkg::fxp_word_t rs2_data;
    fxp_pkg::fxp_word_t operand_1;
    fxp_pkg::fxp_word_t operand_2;
    fxp_pkg::fxp_word_t unit_result;

    fxp_decoder u_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .op          (op_bus.decoder),
        .illegal_now (illegal_now)
    );

    fxp_register_file u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op_bus.consumer),
        .wb       (wb_bus.regfile),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    fxp_forwarding u_forwarding (
        .clk         (clk),
        .rst_n       (rst_n),
        .op          (op_bus.consumer),
        .illegal_now (illegal_now),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .int_operand (int_operand),
        .unit_result (unit_result),
        .operand_1   (operand_1),
        .operand_2   (operand_2),
        .wb          (wb_bus.stage),
        .illegal     (illegal)
    );

    fixed_point_unit #(.FLEN(FLEN)) u_unit (
        .op          (op_bus.consumer),
        .operand_1   (operand_1),
        .operand_2   (operand_2),
        .unit_result (unit_result)
    );

    // Outputs come straight off the writeback stage
    assign result_valid  = wb_bus.valid;
    assign result        = wb_bus.data;
    assign result_is_int = wb_bus.valid & ~wb_bus.writes_fp;

endmodule

`default_nettype wire

// File: logic/fixed_point_unit.sv
`default_nettype none

module fixed_point_unit #(
    parameter int unsigned FLEN = 10                  // Fractional bits
) (
    fxp_op_if.consumer          op,                   // Decoded operation
    input  fxp_pkg::fxp_word_t  operand_1,            // After bypass mux 1
    input  fxp_pkg::fxp_word_t  operand_2,            // After bypass mux 2
    output fxp_pkg::fxp_word_t  unit_result
);

    fxp_pkg::fxp_word_t sum;
    fxp_pkg::fxp_word_t diff;
    fxp_pkg::fxp_word_t to_fixed;
    fxp_pkg::fxp_word_t to_int_s;
    fxp_pkg::fxp_word_t to_int_u;

    // Wraps modulo 2^32
    assign sum  = operand_1 + operand_2;
    assign diff = operand_1 - operand_2;

    // Same bit pattern for signed and unsigned sources
    assign to_fixed = operand_1 << FLEN;

    // W keeps the sign, WU fills with zeros
    assign to_int_s = fxp_pkg::fxp_word_t'($signed(operand_1) >>> FLEN);
    assign to_int_u = operand_1 >> FLEN;

    always_comb begin
        unit_result = '0;                             // Idle or illegal
        if (op.valid) begin
            case (op.op)
                fxp_pkg::OP_ADD:      unit_result = sum;
                fxp_pkg::OP_SUB:      unit_result = diff;
                fxp_pkg::OP_CVT_S_W,
                fxp_pkg::OP_CVT_S_WU: unit_result = to_fixed;
                fxp_pkg::OP_CVT_W_S:  unit_result = to_int_s;
                fxp_pkg::OP_CVT_WU_S: unit_result = to_int_u;
                default:              unit_result = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/fxp_forwarding.sv
`default_nettype none

module fxp_forwarding (
    input  logic                clk,
    input  logic                rst_n,
    fxp_op_if.consumer          op,                   // Instruction in execute
    input  logic                illegal_now,          // Decoder reject this cycle
    input  fxp_pkg::fxp_word_t  rs1_data,             // Register file read 1
    input  fxp_pkg::fxp_word_t  rs2_data,             // Register file read 2
    input  fxp_pkg::fxp_word_t  int_operand,          // Integer source operand
    input  fxp_pkg::fxp_word_t  unit_result,          // Execute result
    output fxp_pkg::fxp_word_t  operand_1,
    output fxp_pkg::fxp_word_t  operand_2,
    fxp_wb_if.stage             wb,                   // Writeback stage
    output logic                illegal               // Registered illegal pulse
);

    logic wb_fp_live;                                 // Stage will write an f reg
    logic fwd_1;
    logic fwd_2;

    // Writeback stage, one cycle behind execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.valid     <= 1'b0;
            wb.rd        <= '0;
            wb.data      <= '0;
            wb.writes_fp <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            wb.valid     <= op.valid;
            wb.rd        <= op.rd;
            wb.data      <= unit_result;
            wb.writes_fp <= op.writes_fp;
            illegal      <= illegal_now;
        end
    end

    assign wb_fp_live = wb.valid & wb.writes_fp;

    // Source matches the stage destination, register file still stale
    assign fwd_1 = op.reads_fp1 & wb_fp_live & (wb.rd == op.rs1);
    assign fwd_2 = op.reads_fp2 & wb_fp_live & (wb.rd == op.rs2);

    always_comb begin
        if (!op.reads_fp1) begin
            operand_1 = int_operand;                  // FCVT.S.W / FCVT.S.WU
        end else if (fwd_1) begin
            operand_1 = wb.data;
        end else begin
            operand_1 = rs1_data;
        end
    end

    assign operand_2 = fwd_2 ? wb.data : rs2_data;

endmodule

`default_nettype wire

// File: logic/fxp_register_file.sv
`default_nettype none

module fxp_register_file (
    input  logic                clk,
    input  logic                rst_n,
    fxp_op_if.consumer          op,                   // Read indices
    fxp_wb_if.regfile           wb,                   // Write port
    output fxp_pkg::fxp_word_t  rs1_data,
    output fxp_pkg::fxp_word_t  rs2_data
);

    fxp_pkg::fxp_word_t regs [fxp_pkg::NUM_FP_REGS];  // f0..f31
    logic               wr_en;

    // Only fixed-point destinations commit here
    assign wr_en = wb.valid & wb.writes_fp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < fxp_pkg::NUM_FP_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;                   // f0 is writable too
        end
    end

    // Combinational reads, same-cycle write handled by the bypass
    assign rs1_data = regs[op.rs1];
    assign rs2_data = regs[op.rs2];

endmodule

`default_nettype wire

// File: logic/fxp_decoder.sv
`default_nettype none

module fxp_decoder (
    input  fxp_pkg::fxp_word_t  instr,                // Instruction word
    input  logic                instr_valid,          // One-cycle strobe
    fxp_op_if.decoder           op,                   // Decoded operation
    output logic                illegal_now           // Unknown encoding this cycle
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;                      // Rounding mode field
    logic [6:0]          funct7;
    fxp_pkg::reg_index_t rs2_field;
    logic                rm_ok;
    logic                legal;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign rs2_field = instr[24:20];

    assign op.rd  = instr[11:7];
    assign op.rs1 = instr[19:15];
    assign op.rs2 = rs2_field;

    // rm 101 and 110 are reserved in the F extension
    assign rm_ok = (funct3 != fxp_pkg::RM_RSVD_A) && (funct3 != fxp_pkg::RM_RSVD_B);

    always_comb begin
        legal        = 1'b0;
        op.op        = fxp_pkg::OP_ADD;
        op.writes_fp = 1'b1;                          // Most ops land in f regs
        op.reads_fp1 = 1'b1;
        op.reads_fp2 = 1'b0;
        if ((opcode == fxp_pkg::OPCODE_OP_FP) && rm_ok) begin
            case (funct7)
                fxp_pkg::FUNCT7_FADD: begin
                    legal        = 1'b1;
                    op.reads_fp2 = 1'b1;
                end
                fxp_pkg::FUNCT7_FSUB: begin
                    legal        = 1'b1;
                    op.op        = fxp_pkg::OP_SUB;
                    op.reads_fp2 = 1'b1;
                end
                fxp_pkg::FUNCT7_FCVT_S_W: begin       // Integer into fixed point
                    legal        = (rs2_field == fxp_pkg::RS2_CVT_SIGNED) ||
                                   (rs2_field == fxp_pkg::RS2_CVT_UNSIGNED);
                    op.op        = rs2_field[0] ? fxp_pkg::OP_CVT_S_WU : fxp_pkg::OP_CVT_S_W;
                    op.reads_fp1 = 1'b0;              // Source is the int operand
                end
                fxp_pkg::FUNCT7_FCVT_W_S: begin       // Fixed point out to integer
                    legal        = (rs2_field == fxp_pkg::RS2_CVT_SIGNED) ||
                                   (rs2_field == fxp_pkg::RS2_CVT_UNSIGNED);
                    op.op        = rs2_field[0] ? fxp_pkg::OP_CVT_WU_S : fxp_pkg::OP_CVT_W_S;
                    op.writes_fp = 1'b0;              // rd is an x register
                end
                default: legal = 1'b0;
            endcase
        end
    end

    assign op.valid    = instr_valid & legal;
    assign illegal_now = instr_valid & ~legal;

endmodule

`default_nettype wire

// File: logic/fxp_if.sv
`default_nettype none

// Decoded operation, decoder to the execute blocks
interface fxp_op_if;
    logic                 valid;                      // Legal instruction this cycle
    fxp_pkg::fxp_op_t     op;                         // Operation code
    fxp_pkg::reg_index_t  rd;                         // Destination index
    fxp_pkg::reg_index_t  rs1;                        // Source 1 index
    fxp_pkg::reg_index_t  rs2;                        // Source 2 index
    logic                 writes_fp;                  // rd is a fixed-point register
    logic                 reads_fp1;                  // Op 1 from FP regs, else int input
    logic                 reads_fp2;                  // Op 2 from FP regs

    modport decoder (
        output valid, op, rd, rs1, rs2, writes_fp, reads_fp1, reads_fp2
    );

    modport consumer (
        input valid, op, rd, rs1, rs2, writes_fp, reads_fp1, reads_fp2
    );
endinterface

// Writeback stage, forwarding stage to register file
interface fxp_wb_if;
    logic                 valid;                      // Stage holds a result
    fxp_pkg::reg_index_t  rd;                         // Destination index
    fxp_pkg::fxp_word_t   data;                       // Result word
    logic                 writes_fp;                  // Commit to FP register file

    modport stage (
        output valid, rd, data, writes_fp
    );

    modport regfile (
        input valid, rd, data, writes_fp
    );
endinterface

`default_nettype wire

// File: logic/fxp_pkg.sv
`default_nettype none

package fxp_pkg;

    // Datapath widths
    typedef logic [31:0] fxp_word_t;                  // Register / operand word
    typedef logic [4:0]  reg_index_t;                 // Register index
    typedef logic [2:0]  fxp_op_t;                    // Decoded operation code

    localparam int unsigned NUM_FP_REGS = 32;         // f0..f31, no hard zero

    // Decoded operation codes
    localparam fxp_op_t OP_ADD      = 3'd0;           // FADD.S
    localparam fxp_op_t OP_SUB      = 3'd1;           // FSUB.S
    localparam fxp_op_t OP_CVT_S_W  = 3'd2;           // Signed int into fixed
    localparam fxp_op_t OP_CVT_S_WU = 3'd3;           // Unsigned int into fixed
    localparam fxp_op_t OP_CVT_W_S  = 3'd4;           // Fixed to signed int
    localparam fxp_op_t OP_CVT_WU_S = 3'd5;           // Fixed to unsigned int

    // OP-FP major opcode
    localparam logic [6:0] OPCODE_OP_FP = 7'b1010011;

    // funct7 of the recognised F-type encodings
    localparam logic [6:0] FUNCT7_FADD     = 7'b0000000;
    localparam logic [6:0] FUNCT7_FSUB     = 7'b0000100;
    localparam logic [6:0] FUNCT7_FCVT_S_W = 7'b1101000; // rs2 picks W / WU
    localparam logic [6:0] FUNCT7_FCVT_W_S = 7'b1100000; // rs2 picks W / WU

    // rs2 field of the conversions
    localparam reg_index_t RS2_CVT_SIGNED   = 5'd0;
    localparam reg_index_t RS2_CVT_UNSIGNED = 5'd1;

    // Reserved rounding modes in funct3
    localparam logic [2:0] RM_RSVD_A = 3'b101;
    localparam logic [2:0] RM_RSVD_B = 3'b110;

endpackage

`default_nettype wire
